//--- all.f
rtl/mem_pkg.sv
rtl/axi_lite_if.sv
rtl/lsu.sv
rtl/ifu.sv
rtl/axi_arbiter.sv
rtl/sram_axi.sv
rtl/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_mem_subsys -f all.f -o tb_mem_subsys
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

	localparam int MEM_WORDS = 256;
	localparam int MEM_BYTES = 4 * MEM_WORDS;
	localparam int WAIT_MAX  = 400; // cycles per handshake

	typedef struct packed {
		logic [31:0] result;
		logic        check_result;
		logic [4:0]  rd;
		logic        reg_write;
		logic        fault;
	} wb_exp_t;

	typedef struct packed {
		logic [31:0] word;
		logic        fault;
	} inst_exp_t;

	logic               clk, rst;
	logic               req_valid, req_ready, req_reg_write;
	mem_pkg::load_op_e  req_load;
	mem_pkg::store_op_e req_store;
	logic [31:0]        req_addr, req_wdata;
	logic [4:0]         req_rd;
	logic               wb_valid, wb_reg_write, wb_fault, wb_ready;
	logic [31:0]        wb_result;
	logic [4:0]         wb_rd;
	logic               fetch_valid, fetch_ready, inst_valid, inst_fault;
	logic [31:0]        fetch_pc, inst;

	logic [7:0]  model [MEM_BYTES]; // byte view of the sram
	wb_exp_t     wb_q[$];
	inst_exp_t   inst_q[$];
	int          errors, timeouts, req_count, fetch_count, wb_seen, inst_seen;
	logic [31:0] lfsr = 32'h22aa_1c18;
	logic        stall_en = 1'b0;
	logic        nonmem_accept, mem_accept_quiet, fetch_accept_quiet;

	mem_subsys_top #(.MEM_WORDS(MEM_WORDS)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic next_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] a);
		logic [31:0] base;
		base = {a[31:2], 2'b00};
		return {model[base + 3], model[base + 2], model[base + 1], model[base]};
	endfunction

	// lane pick and extension per load kind
	function automatic logic [31:0] load_value(input mem_pkg::load_op_e op, input logic [31:0] a);
		logic [7:0]  b;
		logic [15:0] h;
		b = model[a];
		h = {model[a | 32'd1], model[a & ~32'd1]};
		case (op)
			mem_pkg::LD_B:  return {{24{b[7]}}, b};
			mem_pkg::LD_BU: return {24'h0, b};
			mem_pkg::LD_H:  return {{16{h[15]}}, h};
			mem_pkg::LD_HU: return {16'h0, h};
			default:        return word_at(a);
		endcase
	endfunction

	task automatic apply_store(input mem_pkg::store_op_e st, input logic [31:0] a,
			input logic [31:0] d);
		int nbytes;
		nbytes = (st == mem_pkg::ST_B) ? 1 : (st == mem_pkg::ST_H) ? 2 : 4;
		for (int k = 0; k < nbytes; k++)
			model[a + k] = d[8*k +: 8];
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// issue one request, returns once it is accepted
	task automatic lsu_req(input mem_pkg::load_op_e ld, input mem_pkg::store_op_e st,
			input logic [31:0] addr, input logic [31:0] wdata);
		wb_exp_t e;
		int      n;
		req_valid     = 1'b1;
		req_load      = ld;
		req_store     = st;
		req_addr      = addr;
		req_wdata     = wdata;
		req_rd        = 5'(rand_bits(5));
		req_reg_write = rand_bits(1) != 0;
		n = 0;
		@(negedge clk);
		while (!req_ready && n < WAIT_MAX) begin
			n++;
			@(negedge clk);
		end
		if (!req_ready) begin
			$display("timeout waiting for req_ready, request address %h", addr);
			timeouts++;
		end else begin
			e.rd           = req_rd;
			e.reg_write    = req_reg_write;
			e.fault        = (addr >= MEM_BYTES) &&
				(ld != mem_pkg::LD_NONE || st != mem_pkg::ST_NONE);
			e.result       = addr;
			e.check_result = 1'b1;
			if (ld != mem_pkg::LD_NONE) begin
				if (e.fault)
					e.result = '0;
				else
					e.result = load_value(ld, addr);
			end else if (st != mem_pkg::ST_NONE) begin
				e.check_result = 1'b0;
				if (!e.fault)
					apply_store(st, addr, wdata);
			end
			wb_q.push_back(e);
			req_count++;
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic fetch_word(input logic [31:0] pc);
		inst_exp_t e;
		int        n;
		fetch_valid = 1'b1;
		fetch_pc    = pc;
		n = 0;
		@(negedge clk);
		while (!fetch_ready && n < WAIT_MAX) begin
			n++;
			@(negedge clk);
		end
		if (!fetch_ready) begin
			$display("timeout waiting for fetch_ready, pc %h", pc);
			timeouts++;
		end else begin
			e.fault = pc >= MEM_BYTES;
			e.word  = e.fault ? 32'h0 : word_at(pc);
			inst_q.push_back(e);
			fetch_count++;
		end
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
	endtask

	// stores stay in words 0..15, loads roam over words 0..31
	task automatic random_op();
		logic [31:0] kind, word, off;
		kind = rand_bits(3);
		word = rand_bits(5);
		off  = rand_bits(2);
		case (kind)
			32'd0: lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_NONE, rand_bits(32), '0);
			32'd1: lsu_req(mem_pkg::LD_B, mem_pkg::ST_NONE, 4 * word + off, '0);
			32'd2: lsu_req(mem_pkg::LD_BU, mem_pkg::ST_NONE, 4 * word + off, '0);
			32'd3: lsu_req(mem_pkg::LD_H, mem_pkg::ST_NONE, 4 * word + (off & 32'd2), '0);
			32'd4: lsu_req(mem_pkg::LD_HU, mem_pkg::ST_NONE, 4 * word + (off & 32'd2), '0);
			32'd5: lsu_req(mem_pkg::LD_W, mem_pkg::ST_NONE, 4 * word, '0);
			32'd6: lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_B, 4 * word[3:0] + off, rand_bits(32));
			default: begin
				if (off[0])
					lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_H, 4 * word[3:0] + (off & 32'd2),
						rand_bits(32));
				else
					lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_W, 4 * word[3:0], rand_bits(32));
			end
		endcase
	endtask

	always @(negedge clk) begin : wb_monitor
		wb_exp_t e;
		if (!rst && wb_valid && wb_ready) begin
			wb_seen++;
			if (wb_q.size() == 0) begin
				$display("writeback accepted with no request pending");
				errors++;
			end else begin
				e = wb_q.pop_front();
				if (e.check_result)
					check_value("wb_result", wb_result, e.result);
				check_value("wb_rd", 32'(wb_rd), 32'(e.rd));
				check_value("wb_reg_write", 32'(wb_reg_write), 32'(e.reg_write));
				check_value("wb_fault", 32'(wb_fault), 32'(e.fault));
			end
		end
	end

	always @(negedge clk) begin : inst_monitor
		inst_exp_t e;
		if (!rst && inst_valid) begin
			inst_seen++;
			if (inst_q.size() == 0) begin
				$display("inst_valid pulse with no fetch pending");
				errors++;
			end else begin
				e = inst_q.pop_front();
				if (!e.fault)
					check_value("inst", inst, e.word);
				check_value("inst_fault", 32'(inst_fault), 32'(e.fault));
			end
		end
	end

	assign nonmem_accept = req_valid && req_ready &&
		req_load == mem_pkg::LD_NONE && req_store == mem_pkg::ST_NONE;
	assign mem_accept_quiet = req_valid && req_ready && !nonmem_accept &&
		fetch_ready && !fetch_valid; // ifu off the bus
	assign fetch_accept_quiet = fetch_valid && fetch_ready && req_ready && !req_valid;

	nonmem_timing: assert property (@(negedge clk) disable iff (rst)
		$past(nonmem_accept) |-> wb_valid && !wb_fault && wb_result == $past(req_addr))
		else begin
			$display("non-memory request not answered with req_addr one cycle after accept");
			errors++;
		end

	mem_timing: assert property (@(negedge clk) disable iff (rst)
		$past(mem_accept_quiet, 2) |-> wb_valid && !$past(wb_valid))
		else begin
			$display("uncontended load or store did not finish two cycles after accept");
			errors++;
		end

	fetch_timing: assert property (@(negedge clk) disable iff (rst)
		$past(fetch_accept_quiet, 2) |-> inst_valid && !$past(inst_valid))
		else begin
			$display("uncontended fetch did not return two cycles after accept");
			errors++;
		end

	wb_hold: assert property (@(negedge clk) disable iff (rst)
		wb_valid && !wb_ready |=> wb_valid && $stable(wb_result) && $stable(wb_rd) &&
			$stable(wb_reg_write) && $stable(wb_fault))
		else begin
			$display("writeback outputs changed while wb_ready was low");
			errors++;
		end

	busy_lsu: assert property (@(negedge clk) disable iff (rst) wb_valid |-> !req_ready)
		else begin
			$display("req_ready high while a writeback is pending");
			errors++;
		end

	inst_pulse: assert property (@(negedge clk) disable iff (rst)
		inst_valid |=> !inst_valid && !$past(fetch_ready))
		else begin
			$display("inst_valid longer than one cycle or fetch_ready high during it");
			errors++;
		end

	initial begin : stall_drive
		int stall_left;
		stall_left = 0;
		wb_ready   = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (stall_left > 0) begin
				stall_left--;
				wb_ready = 1'b0;
			end else if (stall_en && rand_bits(2) == 0) begin
				stall_left = int'(rand_bits(3));
				wb_ready   = 1'b0;
			end else begin
				wb_ready = 1'b1;
			end
		end
	end

	initial begin : watchdog
		repeat (100000) @(posedge clk);
		$display("watchdog expired before the test sequence finished, errors %0d", errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main
		int n;
		rst           = 1'b1;
		req_valid     = 1'b0;
		req_load      = mem_pkg::LD_NONE;
		req_store     = mem_pkg::ST_NONE;
		req_addr      = '0;
		req_wdata     = '0;
		req_rd        = '0;
		req_reg_write = 1'b0;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("inst_valid", 32'(inst_valid), 32'd0);
		check_value("req_ready", 32'(req_ready), 32'd1);
		check_value("fetch_ready", 32'(fetch_ready), 32'd1);
		@(posedge clk);
		#1;

		repeat (4) lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_NONE, rand_bits(32), rand_bits(32));
		for (int w = 0; w < 32; w++) // preload words 0..31
			lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_W, 4 * w, rand_bits(32));

		for (int w = 4; w < 8; w++) begin
			lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_W, 4 * w, rand_bits(32));
			for (int o = 0; o < 4; o++) begin
				lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_B, 4 * w + o, rand_bits(32));
				lsu_req(mem_pkg::LD_W, mem_pkg::ST_NONE, 4 * w, '0);
			end
			for (int o = 0; o < 4; o += 2) begin
				lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_H, 4 * w + o, rand_bits(32));
				lsu_req(mem_pkg::LD_W, mem_pkg::ST_NONE, 4 * w, '0);
			end
		end

		for (int w = 0; w < 16; w++) begin
			for (int o = 0; o < 4; o++) begin
				lsu_req(mem_pkg::LD_B, mem_pkg::ST_NONE, 4 * w + o, '0);
				lsu_req(mem_pkg::LD_BU, mem_pkg::ST_NONE, 4 * w + o, '0);
			end
			for (int o = 0; o < 4; o += 2) begin
				lsu_req(mem_pkg::LD_H, mem_pkg::ST_NONE, 4 * w + o, '0);
				lsu_req(mem_pkg::LD_HU, mem_pkg::ST_NONE, 4 * w + o, '0);
			end
		end

		stall_en = 1'b1;
		repeat (60) random_op();
		fork
			repeat (80) random_op();
			repeat (40) fetch_word(32'd64 + 4 * rand_bits(4)); // words 16..31
		join
		stall_en = 1'b0;

		lsu_req(mem_pkg::LD_W, mem_pkg::ST_NONE, 32'd1024, '0);
		lsu_req(mem_pkg::LD_B, mem_pkg::ST_NONE, 32'd1031, '0);
		lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_W, 32'd1032, rand_bits(32)); // aliases word 2
		lsu_req(mem_pkg::LD_NONE, mem_pkg::ST_B, 32'h0001_0005, rand_bits(32));
		lsu_req(mem_pkg::LD_W, mem_pkg::ST_NONE, 32'd8, '0);
		lsu_req(mem_pkg::LD_B, mem_pkg::ST_NONE, 32'd5, '0);
		fetch_word(32'd1024);
		fetch_word(32'h0000_2000);
		fetch_word(32'd64);

		n = 0;
		while ((wb_q.size() != 0 || inst_q.size() != 0) && n < WAIT_MAX) begin
			@(posedge clk);
			n++;
		end
		if (wb_q.size() != 0 || inst_q.size() != 0) begin
			$display("timeout waiting for outstanding writebacks and fetches");
			timeouts++;
		end
		check_value("writeback count", wb_seen, req_count);
		check_value("fetch count", inst_seen, fetch_count);

		$display("writebacks %0d, fetches %0d, errors %0d, timeouts %0d",
			wb_seen, inst_seen, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- rtl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                         clk,
	input  logic                         rst,

	input  logic                         req_valid,
	input  mem_pkg::load_op_e            req_load,
	input  mem_pkg::store_op_e           req_store,
	input  logic [mem_pkg::ADDR_W-1:0]   req_addr,
	input  logic [mem_pkg::DATA_W-1:0]   req_wdata,
	input  logic [mem_pkg::REGS_DIG-1:0] req_rd,
	input  logic                         req_reg_write,
	output logic                         req_ready,

	output logic                         wb_valid,
	output logic [mem_pkg::DATA_W-1:0]   wb_result,
	output logic [mem_pkg::REGS_DIG-1:0] wb_rd,
	output logic                         wb_reg_write,
	output logic                         wb_fault,
	input  logic                         wb_ready,

	input  logic                         fetch_valid,
	input  logic [mem_pkg::ADDR_W-1:0]   fetch_pc,
	output logic                         fetch_ready,
	output logic                         inst_valid,
	output logic [mem_pkg::DATA_W-1:0]   inst,
	output logic                         inst_fault
);

	mem_pkg::wb_tag_t req_tag, wb_tag;

	axi_lite_if lsu_bus ();
	axi_lite_if ifu_bus ();
	axi_lite_if mem_bus ();

	assign req_tag.rd        = req_rd;
	assign req_tag.reg_write = req_reg_write;
	assign wb_rd             = wb_tag.rd;
	assign wb_reg_write      = wb_tag.reg_write;

	lsu lsu_i (
		.clk, .rst,
		.req_valid, .req_load, .req_store, .req_addr, .req_wdata, .req_tag, .req_ready,
		.wb_valid, .wb_result, .wb_tag, .wb_fault, .wb_ready,
		.bus (lsu_bus.master)
	);

	ifu ifu_i (
		.clk, .rst,
		.fetch_valid, .fetch_pc, .fetch_ready, .inst_valid, .inst, .inst_fault,
		.bus (ifu_bus.master)
	);

	axi_arbiter arb_i (
		.clk, .rst,
		.m0 (lsu_bus.slave),
		.m1 (ifu_bus.slave),
		.s  (mem_bus.master)
	);

	sram_axi #(.MEM_WORDS(MEM_WORDS)) sram_i (
		.clk, .rst,
		.bus (mem_bus.slave)
	);

endmodule

//--- rtl/sram_axi.sv
`timescale 1ns/1ps

module sram_axi #(
	parameter int MEM_WORDS = 1024
) (
	input  logic      clk,
	input  logic      rst,
	axi_lite_if.slave bus
);

	localparam int          IDX_W     = $clog2(MEM_WORDS);
	localparam int unsigned MEM_BYTES = 4 * MEM_WORDS;

	logic [mem_pkg::DATA_W-1:0]   mem [MEM_WORDS];

	logic                         rvalid_q, bvalid_q, aw_got, w_got, idle;
	logic                         ar_hs, aw_hs, w_hs, do_write, wr_ok;
	logic [mem_pkg::ADDR_W-1:0]   awaddr_q, waddr_c;
	logic [mem_pkg::DATA_W-1:0]   wdata_q, wdata_c;
	logic [mem_pkg::DATA_W/8-1:0] wstrb_q, wstrb_c;

	assign idle = !rvalid_q && !bvalid_q;

	assign bus.arready = idle && !aw_got && !w_got;
	assign bus.awready = idle && !aw_got;
	assign bus.wready  = idle && !w_got;
	assign bus.rvalid  = rvalid_q;
	assign bus.bvalid  = bvalid_q;

	assign ar_hs = bus.arvalid && bus.arready;
	assign aw_hs = bus.awvalid && bus.awready;
	assign w_hs  = bus.wvalid && bus.wready;

	// latched half or the one arriving now
	assign waddr_c  = aw_got ? awaddr_q : bus.awaddr;
	assign wdata_c  = w_got ? wdata_q : bus.wdata;
	assign wstrb_c  = w_got ? wstrb_q : bus.wstrb;
	assign do_write = (aw_got || aw_hs) && (w_got || w_hs);
	assign wr_ok    = waddr_c < MEM_BYTES;

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
		end else begin
			if (ar_hs)
				rvalid_q <= 1'b1;
			else if (bus.rready)
				rvalid_q <= 1'b0;
			if (do_write) begin
				bvalid_q <= 1'b1;
				aw_got   <= 1'b0;
				w_got    <= 1'b0;
			end else begin
				if (bus.bready)
					bvalid_q <= 1'b0;
				if (aw_hs)
					aw_got <= 1'b1;
				if (w_hs)
					w_got <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= bus.awaddr;
		if (w_hs) begin
			wdata_q <= bus.wdata;
			wstrb_q <= bus.wstrb;
		end
		if (ar_hs) begin
			if (bus.araddr < MEM_BYTES) begin
				bus.rdata <= mem[bus.araddr[IDX_W+1:2]];
				bus.rresp <= mem_pkg::RESP_OKAY;
			end else begin
				bus.rdata <= '0;
				bus.rresp <= mem_pkg::RESP_SLVERR;
			end
		end
		if (do_write) begin
			bus.bresp <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
			for (int b = 0; b < mem_pkg::DATA_W / 8; b++)
				if (wr_ok && wstrb_c[b])
					mem[waddr_c[IDX_W+1:2]][8*b +: 8] <= wdata_c[8*b +: 8];
		end
	end

endmodule

//--- rtl/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
	input  logic       clk,
	input  logic       rst,
	axi_lite_if.slave  m0, // lsu
	axi_lite_if.slave  m1, // ifu
	axi_lite_if.master s
);

	logic locked_q, owner_q, last_q;
	logic req0, req1, gnt, sel, active, g0, g1, done;

	assign req0 = m0.arvalid || m0.awvalid;
	assign req1 = m1.arvalid || m1.awvalid;

	// round robin, the one not served last wins a tie
	assign gnt    = (req0 && req1) ? !last_q : req1;
	assign sel    = locked_q ? owner_q : gnt;
	assign active = locked_q || req0 || req1;
	assign g0     = active && !sel;
	assign g1     = active && sel;

	// requests from the owner
	assign s.araddr  = sel ? m1.araddr : m0.araddr;
	assign s.arvalid = sel ? m1.arvalid : m0.arvalid;
	assign s.rready  = sel ? m1.rready : m0.rready;
	assign s.awaddr  = sel ? m1.awaddr : m0.awaddr;
	assign s.awvalid = sel ? m1.awvalid : m0.awvalid;
	assign s.wdata   = sel ? m1.wdata : m0.wdata;
	assign s.wstrb   = sel ? m1.wstrb : m0.wstrb;
	assign s.wvalid  = sel ? m1.wvalid : m0.wvalid;
	assign s.bready  = sel ? m1.bready : m0.bready;

	// readys and responses only to the owner
	assign m0.arready = g0 && s.arready;
	assign m0.awready = g0 && s.awready;
	assign m0.wready  = g0 && s.wready;
	assign m0.rvalid  = g0 && s.rvalid;
	assign m0.bvalid  = g0 && s.bvalid;
	assign m0.rdata   = s.rdata;
	assign m0.rresp   = s.rresp;
	assign m0.bresp   = s.bresp;

	assign m1.arready = g1 && s.arready;
	assign m1.awready = g1 && s.awready;
	assign m1.wready  = g1 && s.wready;
	assign m1.rvalid  = g1 && s.rvalid;
	assign m1.bvalid  = g1 && s.bvalid;
	assign m1.rdata   = s.rdata;
	assign m1.rresp   = s.rresp;
	assign m1.bresp   = s.bresp;

	assign done = locked_q && ((s.rvalid && s.rready) || (s.bvalid && s.bready));

	always_ff @(posedge clk) begin
		if (rst) begin
			locked_q <= 1'b0;
			owner_q  <= 1'b0;
			last_q   <= 1'b1; // counts as ifu so lsu goes first
		end else if (!locked_q && (req0 || req1)) begin
			locked_q <= 1'b1;
			owner_q  <= gnt;
		end else if (done) begin
			locked_q <= 1'b0;
			last_q   <= owner_q;
		end
	end

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps

module ifu (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       fetch_valid,
	input  logic [mem_pkg::ADDR_W-1:0] fetch_pc,
	output logic                       fetch_ready,
	output logic                       inst_valid,
	output logic [mem_pkg::DATA_W-1:0] inst,
	output logic                       inst_fault,
	axi_lite_if.master                 bus
);

	typedef enum logic [1:0] {S_IDLE, S_WAIT_AR, S_WAIT_R} state_e;

	state_e                     state_q;
	logic                       idle, accept;
	logic [mem_pkg::ADDR_W-1:0] pc_q;

	assign idle        = state_q == S_IDLE;
	assign fetch_ready = idle && !inst_valid; // still busy in the pulse cycle
	assign accept      = fetch_valid && fetch_ready;

	assign bus.araddr  = idle ? {fetch_pc[mem_pkg::ADDR_W-1:2], 2'b00} : pc_q;
	assign bus.arvalid = (state_q == S_WAIT_AR) || accept;
	assign bus.rready  = state_q == S_WAIT_R;

	// read only master
	assign bus.awaddr  = '0;
	assign bus.awvalid = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wstrb   = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.bready  = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q    <= S_IDLE;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= bus.rvalid && bus.rready;
			case (state_q)
				S_IDLE:    if (accept) state_q <= bus.arready ? S_WAIT_R : S_WAIT_AR;
				S_WAIT_AR: if (bus.arready) state_q <= S_WAIT_R;
				S_WAIT_R:  if (bus.rvalid) state_q <= S_IDLE;
				default:   state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pc_q <= {fetch_pc[mem_pkg::ADDR_W-1:2], 2'b00};
		if (bus.rvalid && bus.rready) begin
			inst       <= bus.rdata;
			inst_fault <= bus.rresp != mem_pkg::RESP_OKAY;
		end
	end

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_valid,
	input  mem_pkg::load_op_e          req_load,
	input  mem_pkg::store_op_e         req_store,
	input  logic [mem_pkg::ADDR_W-1:0] req_addr,
	input  logic [mem_pkg::DATA_W-1:0] req_wdata,
	input  mem_pkg::wb_tag_t           req_tag,
	output logic                       req_ready,
	output logic                       wb_valid,
	output logic [mem_pkg::DATA_W-1:0] wb_result,
	output mem_pkg::wb_tag_t           wb_tag,
	output logic                       wb_fault,
	input  logic                       wb_ready,
	axi_lite_if.master                 bus
);

	typedef enum logic [2:0] {
		S_IDLE, S_WAIT_AR, S_WAIT_AW_W, S_WAIT_AW,
		S_WAIT_W, S_WAIT_R, S_WAIT_B, S_WAIT_WB
	} state_e;

	state_e state_q, state_d, aw_w_next;

	logic                         is_load, is_store, idle;
	logic [mem_pkg::DATA_W-1:0]   st_data, ld_ext;
	logic [mem_pkg::DATA_W/8-1:0] st_strb;
	logic [7:0]                   ld_byte;
	logic [15:0]                  ld_half;

	logic [mem_pkg::ADDR_W-1:0]   addr_q;
	mem_pkg::load_op_e            load_q;
	logic [mem_pkg::DATA_W-1:0]   wdata_q, result_q;
	logic [mem_pkg::DATA_W/8-1:0] wstrb_q;
	mem_pkg::wb_tag_t             tag_q;
	logic                         fault_q;

	assign is_load  = req_load != mem_pkg::LD_NONE;
	assign is_store = req_store != mem_pkg::ST_NONE;
	assign idle     = state_q == S_IDLE;

	assign req_ready = idle;

	// lane placement, low address bits pick the byte or half
	always_comb begin
		case (req_store)
			mem_pkg::ST_B: begin
				st_data = mem_pkg::DATA_W'(req_wdata[7:0]) << {req_addr[1:0], 3'b000};
				st_strb = 4'b0001 << req_addr[1:0];
			end
			mem_pkg::ST_H: begin
				st_data = mem_pkg::DATA_W'(req_wdata[15:0]) << {req_addr[1], 4'b0000};
				st_strb = 4'b0011 << {req_addr[1], 1'b0};
			end
			mem_pkg::ST_W: begin
				st_data = req_wdata;
				st_strb = 4'b1111;
			end
			default: begin
				st_data = '0;
				st_strb = '0;
			end
		endcase
	end

	// address phase starts in the accept cycle, later from the registers
	assign bus.araddr  = idle ? req_addr : addr_q;
	assign bus.awaddr  = idle ? req_addr : addr_q;
	assign bus.wdata   = idle ? st_data : wdata_q;
	assign bus.wstrb   = idle ? st_strb : wstrb_q;
	assign bus.arvalid = (state_q == S_WAIT_AR) || (idle && req_valid && is_load);
	assign bus.awvalid = (state_q == S_WAIT_AW_W) || (state_q == S_WAIT_AW) ||
		(idle && req_valid && !is_load && is_store);
	assign bus.wvalid  = (state_q == S_WAIT_AW_W) || (state_q == S_WAIT_W) ||
		(idle && req_valid && !is_load && is_store);
	assign bus.rready  = state_q == S_WAIT_R;
	assign bus.bready  = state_q == S_WAIT_B;

	// aw and w may land in either order
	always_comb begin
		case ({bus.awready, bus.wready})
			2'b11:   aw_w_next = S_WAIT_B;
			2'b10:   aw_w_next = S_WAIT_W;
			2'b01:   aw_w_next = S_WAIT_AW;
			default: aw_w_next = S_WAIT_AW_W;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: if (req_valid) begin
				if (is_load)
					state_d = bus.arready ? S_WAIT_R : S_WAIT_AR;
				else if (is_store)
					state_d = aw_w_next;
				else
					state_d = S_WAIT_WB;
			end
			S_WAIT_AR:   if (bus.arready) state_d = S_WAIT_R;
			S_WAIT_AW_W: state_d = aw_w_next;
			S_WAIT_AW:   if (bus.awready) state_d = S_WAIT_B;
			S_WAIT_W:    if (bus.wready) state_d = S_WAIT_B;
			S_WAIT_R:    if (bus.rvalid) state_d = S_WAIT_WB;
			S_WAIT_B:    if (bus.bvalid) state_d = S_WAIT_WB;
			S_WAIT_WB:   if (wb_ready) state_d = S_IDLE;
			default:     state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= S_IDLE;
		else
			state_q <= state_d;
	end

	// pick the addressed lane and extend it
	assign ld_byte = bus.rdata[{addr_q[1:0], 3'b000} +: 8];
	assign ld_half = addr_q[1] ? bus.rdata[31:16] : bus.rdata[15:0];

	always_comb begin
		case (load_q)
			mem_pkg::LD_B:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
			mem_pkg::LD_BU: ld_ext = {24'b0, ld_byte};
			mem_pkg::LD_H:  ld_ext = {{16{ld_half[15]}}, ld_half};
			mem_pkg::LD_HU: ld_ext = {16'b0, ld_half};
			default:        ld_ext = bus.rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			addr_q   <= req_addr;
			load_q   <= req_load;
			wdata_q  <= st_data;
			wstrb_q  <= st_strb;
			tag_q    <= req_tag;
			result_q <= req_addr; // non-memory result
			fault_q  <= 1'b0;
		end else if (bus.rvalid && bus.rready) begin
			result_q <= (bus.rresp == mem_pkg::RESP_OKAY) ? ld_ext : '0;
			fault_q  <= bus.rresp != mem_pkg::RESP_OKAY;
		end else if (bus.bvalid && bus.bready) begin
			fault_q <= bus.bresp != mem_pkg::RESP_OKAY;
		end
	end

	assign wb_valid  = state_q == S_WAIT_WB;
	assign wb_result = result_q;
	assign wb_tag    = tag_q;
	assign wb_fault  = fault_q;

endmodule

//--- rtl/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;

	logic [mem_pkg::ADDR_W-1:0]   araddr;
	logic                         arvalid;
	logic                         arready;

	logic [mem_pkg::DATA_W-1:0]   rdata;
	mem_pkg::resp_e               rresp;
	logic                         rvalid;
	logic                         rready;

	logic [mem_pkg::ADDR_W-1:0]   awaddr;
	logic                         awvalid;
	logic                         awready;

	logic [mem_pkg::DATA_W-1:0]   wdata;
	logic [mem_pkg::DATA_W/8-1:0] wstrb; // one bit per byte lane
	logic                         wvalid;
	logic                         wready;

	mem_pkg::resp_e               bresp;
	logic                         bvalid;
	logic                         bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport slave (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

endinterface

//--- rtl/mem_pkg.sv
package mem_pkg;

	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;
	localparam int REGS_DIG = 5; // register index width

	// load kind from execute
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_B    = 3'd1,
		LD_H    = 3'd2,
		LD_W    = 3'd3,
		LD_BU   = 3'd4,
		LD_HU   = 3'd5
	} load_op_e;

	// store kind from execute
	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_B    = 2'd1,
		ST_H    = 2'd2,
		ST_W    = 2'd3
	} store_op_e;

	// AXI response codes, only the two the SRAM uses
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// rides along from execute to writeback untouched
	typedef struct packed {
		logic [REGS_DIG-1:0] rd;
		logic                reg_write;
	} wb_tag_t;

endpackage
